// ==== logic/cpuPkg.sv ====
// shared types and constants for the reduced 6502 core
// widths, opcodes, vectors, flag positions and control encodings
package cpuPkg;

  typedef logic [7:0]  byteT;
  typedef logic [15:0] addrT;

  typedef enum logic [2:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluEor, aluPassB, aluInc
  } aluOpT;

  typedef enum logic [1:0] {addrPc, addrOp, addrStack, addrVec} addrSelT;

  typedef enum logic [2:0] {dataPch, dataPcl, dataP, dataA, dataX} dataSelT;

  typedef enum logic [3:0] {
    vectorLo, vectorHi, fetch, operandLo, operandHi, branch, writeOp,
    pushPch, pushPcl, pushP, intVecLo, intVecHi
  } seqStateT;

  // status register bit positions
  localparam int FLAG_C = 0;
  localparam int FLAG_Z = 1;
  localparam int FLAG_I = 2;
  localparam int FLAG_D = 3;
  localparam int FLAG_N = 7;

  localparam addrT NMI_VEC    = 16'hFFFA;
  localparam addrT RESET_VEC  = 16'hFFFC;
  localparam addrT IRQ_VEC    = 16'hFFFE;
  localparam byteT STACK_PAGE = 8'h01;
  localparam byteT SP_RESET   = 8'hFD;

  localparam byteT OP_LDA_IMM = 8'hA9;
  localparam byteT OP_LDX_IMM = 8'hA2;
  localparam byteT OP_ADC_IMM = 8'h69;
  localparam byteT OP_SBC_IMM = 8'hE9;
  localparam byteT OP_AND_IMM = 8'h29;
  localparam byteT OP_ORA_IMM = 8'h09;
  localparam byteT OP_EOR_IMM = 8'h49;
  localparam byteT OP_STA_ABS = 8'h8D;
  localparam byteT OP_STX_ABS = 8'h8E;
  localparam byteT OP_JMP_ABS = 8'h4C;
  localparam byteT OP_BEQ     = 8'hF0;
  localparam byteT OP_BNE     = 8'hD0;
  localparam byteT OP_INX     = 8'hE8;
  localparam byteT OP_TAX     = 8'hAA;
  localparam byteT OP_SEC     = 8'h38;
  localparam byteT OP_CLC     = 8'h18;
  localparam byteT OP_SED     = 8'hF8;
  localparam byteT OP_CLD     = 8'hD8;
  localparam byteT OP_CLI     = 8'h58;
  localparam byteT OP_NOP     = 8'hEA;

endpackage

// ==== logic/cpuCtrlIf.sv ====
// control fields from the sequencer to the datapath, Z and I flags back
`timescale 1ns/1ps
interface cpuCtrlIf import cpuPkg::*; ();

  aluOpT   aluOp;
  logic    loadA, loadX, loadOpLo, loadOpHi;
  logic    loadPcFromOp, loadPcFromVec, loadPcBranch;
  logic    incPc, decSp;
  addrSelT addrSel;
  dataSelT dataSel;
  logic    setC, clrC, setD, clrD, setI, clrI, updNZ, updC;
  // ALU b operand from A instead of the bus (register transfer)
  logic    bFromA;
  addrT    vecAddr;
  logic    flagZ, flagI;

  modport sequencer (
    output aluOp, loadA, loadX, loadOpLo, loadOpHi, loadPcFromOp, loadPcFromVec,
           loadPcBranch, incPc, decSp, addrSel, dataSel, setC, clrC, setD, clrD,
           setI, clrI, updNZ, updC, bFromA, vecAddr,
    input  flagZ, flagI
  );

  modport datapath (
    input  aluOp, loadA, loadX, loadOpLo, loadOpHi, loadPcFromOp, loadPcFromVec,
           loadPcBranch, incPc, decSp, addrSel, dataSel, setC, clrC, setD, clrD,
           setI, clrI, updNZ, updC, bFromA, vecAddr,
    output flagZ, flagI
  );

endinterface

// ==== logic/alu.sv ====
// ALU with binary and BCD add/subtract and the logic operations
`timescale 1ns/1ps
module alu import cpuPkg::*; (
  input  byteT  a,
  input  byteT  b,
  input  aluOpT op,
  input  logic  carryIn,
  input  logic  decimal,
  output byteT  result,
  output logic  carryOut
);

  // one digit per nibble, bit 4 is the carry or borrow
  logic [4:0] lo, hi;
  logic       loBorrow, hiBorrow;

  always_comb begin
    lo = '0;
    hi = '0;
    loBorrow = 1'b0;
    hiBorrow = 1'b0;
    result = b;
    carryOut = carryIn;
    unique case (op)
      aluAdd: begin
        lo = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'b0, carryIn};
        if (decimal && lo > 5'd9) lo = lo + 5'd6;
        hi = {1'b0, a[7:4]} + {1'b0, b[7:4]} + {4'b0, lo[4]};
        if (decimal && hi > 5'd9) hi = hi + 5'd6;
        result = {hi[3:0], lo[3:0]};
        carryOut = hi[4];
      end
      aluSub: begin
        // carry set means no borrow in
        lo = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'b0, ~carryIn};
        loBorrow = lo[4];
        if (decimal && loBorrow) lo = lo - 5'd6;
        hi = {1'b0, a[7:4]} - {1'b0, b[7:4]} - {4'b0, loBorrow};
        hiBorrow = hi[4];
        if (decimal && hiBorrow) hi = hi - 5'd6;
        result = {hi[3:0], lo[3:0]};
        carryOut = ~hiBorrow;
      end
      aluAnd: result = a & b;
      aluOr:  result = a | b;
      aluEor: result = a ^ b;
      aluInc: result = a + 8'd1;
      default: result = b;
    endcase
  end

endmodule

// ==== logic/datapath.sv ====
// register file, program counter and status flags of the core
// also selects the bus address and the write data
`timescale 1ns/1ps
module datapath import cpuPkg::*; (
  input  logic phi0,
  input  logic rst,
  cpuCtrlIf.datapath ctrl,
  input  byteT busRdData,
  output addrT busAdr,
  output byteT busWrData
);

  byteT regA, regX, regS, regP;
  byteT opLo, opHi;
  addrT pc, pcInc, pcBranch;
  byteT aluA, aluB, aluResult;
  logic aluCarry;

  // INX works on X, everything else on A
  assign aluA = (ctrl.aluOp == aluInc) ? regX : regA;
  assign aluB = ctrl.bFromA ? regA : busRdData;

  alu aluInst (
    .a        (aluA),
    .b        (aluB),
    .op       (ctrl.aluOp),
    .carryIn  (regP[FLAG_C]),
    .decimal  (regP[FLAG_D]),
    .result   (aluResult),
    .carryOut (aluCarry)
  );

  assign pcInc = pc + 16'd1;
  // signed offset relative to the byte after the operand
  assign pcBranch = pc + {{8{opLo[7]}}, opLo};

  always_ff @(posedge phi0) begin
    if (ctrl.loadA) regA <= aluResult;
    if (ctrl.loadX) regX <= aluResult;
    if (ctrl.loadOpLo) opLo <= busRdData;
    if (ctrl.loadOpHi) opHi <= busRdData;
    if (ctrl.loadPcFromOp || ctrl.loadPcFromVec) begin
      pc <= {busRdData, opLo};
    end else if (ctrl.loadPcBranch) begin
      pc <= pcBranch;
    end else if (ctrl.incPc) begin
      pc <= pcInc;
    end
  end

  always_ff @(posedge phi0) begin
    if (rst) begin
      regS <= SP_RESET;
      regP <= '0;
      regP[FLAG_I] <= 1'b1;
    end else begin
      if (ctrl.decSp) regS <= regS - 8'd1;
      if (ctrl.updNZ) begin
        regP[FLAG_N] <= aluResult[7];
        regP[FLAG_Z] <= (aluResult == 8'h00);
      end
      if (ctrl.updC) regP[FLAG_C] <= aluCarry;
      else if (ctrl.setC) regP[FLAG_C] <= 1'b1;
      else if (ctrl.clrC) regP[FLAG_C] <= 1'b0;
      if (ctrl.setD) regP[FLAG_D] <= 1'b1;
      else if (ctrl.clrD) regP[FLAG_D] <= 1'b0;
      if (ctrl.setI) regP[FLAG_I] <= 1'b1;
      else if (ctrl.clrI) regP[FLAG_I] <= 1'b0;
    end
  end

  assign ctrl.flagZ = regP[FLAG_Z];
  assign ctrl.flagI = regP[FLAG_I];

  always_comb begin
    unique case (ctrl.addrSel)
      addrPc:    busAdr = pc;
      addrOp:    busAdr = {opHi, opLo};
      addrStack: busAdr = {STACK_PAGE, regS};
      default:   busAdr = ctrl.vecAddr;
    endcase
  end

  always_comb begin
    unique case (ctrl.dataSel)
      dataPch: busWrData = pc[15:8];
      dataPcl: busWrData = pc[7:0];
      // pushed status has bit 5 set and B clear
      dataP:   busWrData = regP | 8'h20;
      dataX:   busWrData = regX;
      default: busWrData = regA;
    endcase
  end

endmodule

// ==== logic/sequencer.sv ====
// instruction register, timing FSM and control decode
// runs one Wishbone classic access per state
`timescale 1ns/1ps
module sequencer import cpuPkg::*; (
  input  logic phi0,
  input  logic rst,
  cpuCtrlIf.sequencer ctrl,
  input  byteT busRdData,
  input  logic busAck,
  output logic busWe,
  output logic busCyc,
  output logic busStb,
  output logic sync,
  input  logic nmiPending,
  input  logic irqPending,
  output logic intTaken,
  output logic intIsNmi
);

  seqStateT state, nextState;
  byteT     ir, opcode;
  logic     strobe, fire, weState, takeInt, servingNmi;
  addrT     vecBase;

  assign fire = strobe & busAck;
  // implied ops finish on the fetch itself, so decode the bus byte there
  assign opcode = (state == fetch) ? busRdData : ir;

  always_ff @(posedge phi0) begin
    if (rst) begin
      state <= vectorLo;
      strobe <= 1'b0;
      servingNmi <= 1'b0;
    end else if (!strobe) begin
      strobe <= 1'b1;
    end else if (busAck) begin
      strobe <= 1'b0;
      state <= nextState;
      if (takeInt) servingNmi <= nmiPending;
    end
  end

  always_ff @(posedge phi0) begin
    if (fire && state == fetch) ir <= busRdData;
  end

  // bus side, stable for the whole strobe
  always_comb begin
    ctrl.addrSel = addrPc;
    ctrl.dataSel = dataA;
    weState = 1'b0;
    unique case (state)
      vectorLo, vectorHi, intVecLo, intVecHi: ctrl.addrSel = addrVec;
      writeOp: begin
        ctrl.addrSel = addrOp;
        ctrl.dataSel = (opcode == OP_STX_ABS) ? dataX : dataA;
        weState = 1'b1;
      end
      pushPch, pushPcl, pushP: begin
        ctrl.addrSel = addrStack;
        ctrl.dataSel = (state == pushPch) ? dataPch : (state == pushPcl) ? dataPcl : dataP;
        weState = 1'b1;
      end
      default: ctrl.addrSel = addrPc;
    endcase
  end

  always_comb begin
    if (state == vectorLo || state == vectorHi) vecBase = RESET_VEC;
    else vecBase = servingNmi ? NMI_VEC : IRQ_VEC;
  end
  assign ctrl.vecAddr = vecBase | addrT'(state == vectorHi || state == intVecHi);

  // strobes act only on the acknowledging edge
  always_comb begin
    ctrl.aluOp = aluPassB;
    ctrl.bFromA = 1'b0;
    ctrl.loadA = 1'b0;
    ctrl.loadX = 1'b0;
    ctrl.loadOpLo = 1'b0;
    ctrl.loadOpHi = 1'b0;
    ctrl.loadPcFromOp = 1'b0;
    ctrl.loadPcFromVec = 1'b0;
    ctrl.loadPcBranch = 1'b0;
    ctrl.incPc = 1'b0;
    ctrl.decSp = 1'b0;
    ctrl.setC = 1'b0;
    ctrl.clrC = 1'b0;
    ctrl.setD = 1'b0;
    ctrl.clrD = 1'b0;
    ctrl.setI = 1'b0;
    ctrl.clrI = 1'b0;
    ctrl.updNZ = 1'b0;
    ctrl.updC = 1'b0;
    nextState = state;
    takeInt = 1'b0;
    if (fire) begin
      nextState = fetch;
      unique case (state)
        vectorLo, intVecLo: begin
          ctrl.loadOpLo = 1'b1;
          nextState = (state == vectorLo) ? vectorHi : intVecHi;
        end
        vectorHi, intVecHi: ctrl.loadPcFromVec = 1'b1;
        fetch: begin
          ctrl.incPc = 1'b1;
          case (opcode)
            OP_INX: begin
              ctrl.aluOp = aluInc;
              ctrl.loadX = 1'b1;
              ctrl.updNZ = 1'b1;
            end
            OP_TAX: begin
              ctrl.bFromA = 1'b1;
              ctrl.loadX = 1'b1;
              ctrl.updNZ = 1'b1;
            end
            OP_SEC: ctrl.setC = 1'b1;
            OP_CLC: ctrl.clrC = 1'b1;
            OP_SED: ctrl.setD = 1'b1;
            OP_CLD: ctrl.clrD = 1'b1;
            OP_CLI: ctrl.clrI = 1'b1;
            OP_LDA_IMM, OP_LDX_IMM, OP_ADC_IMM, OP_SBC_IMM, OP_AND_IMM, OP_ORA_IMM,
            OP_EOR_IMM, OP_STA_ABS, OP_STX_ABS, OP_JMP_ABS, OP_BEQ, OP_BNE:
              nextState = operandLo;
            // NOP and unknown opcodes
            default: nextState = fetch;
          endcase
        end
        operandLo: begin
          ctrl.incPc = 1'b1;
          ctrl.updNZ = 1'b1;
          ctrl.loadA = 1'b1;
          case (opcode)
            OP_ADC_IMM: begin
              ctrl.aluOp = aluAdd;
              ctrl.updC = 1'b1;
            end
            OP_SBC_IMM: begin
              ctrl.aluOp = aluSub;
              ctrl.updC = 1'b1;
            end
            OP_AND_IMM: ctrl.aluOp = aluAnd;
            OP_ORA_IMM: ctrl.aluOp = aluOr;
            OP_EOR_IMM: ctrl.aluOp = aluEor;
            OP_LDA_IMM: ctrl.aluOp = aluPassB;
            OP_LDX_IMM: begin
              ctrl.loadA = 1'b0;
              ctrl.loadX = 1'b1;
            end
            default: begin
              // operand byte of a branch or an absolute address
              ctrl.loadA = 1'b0;
              ctrl.updNZ = 1'b0;
              ctrl.loadOpLo = 1'b1;
              if (opcode == OP_BEQ) nextState = ctrl.flagZ ? branch : fetch;
              else if (opcode == OP_BNE) nextState = ctrl.flagZ ? fetch : branch;
              else nextState = operandHi;
            end
          endcase
        end
        operandHi: begin
          if (opcode == OP_JMP_ABS) begin
            ctrl.loadPcFromOp = 1'b1;
          end else begin
            ctrl.incPc = 1'b1;
            ctrl.loadOpHi = 1'b1;
            nextState = writeOp;
          end
        end
        branch: ctrl.loadPcBranch = 1'b1;
        pushPch: begin
          ctrl.decSp = 1'b1;
          nextState = pushPcl;
        end
        pushPcl: begin
          ctrl.decSp = 1'b1;
          nextState = pushP;
        end
        pushP: begin
          ctrl.decSp = 1'b1;
          ctrl.setI = 1'b1;
          nextState = intVecLo;
        end
        default: nextState = fetch;
      endcase
      // fetch boundary, NMI wins over IRQ
      if (nextState == fetch && (nmiPending || irqPending)) begin
        nextState = pushPch;
        takeInt = 1'b1;
      end
    end
  end

  assign intTaken = takeInt;
  assign intIsNmi = nmiPending;
  assign busCyc = strobe;
  assign busStb = strobe;
  assign busWe = strobe & weState;
  assign sync = strobe & (state == fetch);

endmodule

// ==== logic/interruptControl.sv ====
// NMI edge latch and masked IRQ level for the sequencer
`timescale 1ns/1ps
module interruptControl (
  input  logic phi0,
  input  logic rst,
  input  logic nmi,
  input  logic irq,
  input  logic flagI,
  input  logic intTaken,
  input  logic intIsNmi,
  output logic nmiPending,
  output logic irqPending
);

  logic [1:0] nmiSync, irqSync;
  logic       nmiPrev, nmiLatch;

  always_ff @(posedge phi0) begin
    if (rst) begin
      nmiSync <= '0;
      irqSync <= '0;
      nmiPrev <= 1'b0;
      nmiLatch <= 1'b0;
    end else begin
      nmiSync <= {nmiSync[0], nmi};
      irqSync <= {irqSync[0], irq};
      nmiPrev <= nmiSync[1];
      // a new edge wins over the acknowledge
      if (nmiSync[1] && !nmiPrev) nmiLatch <= 1'b1;
      else if (intTaken && intIsNmi) nmiLatch <= 1'b0;
    end
  end

  assign nmiPending = nmiLatch;
  assign irqPending = irqSync[1] & ~flagI;

endmodule

// ==== logic/cpu6502Top.sv ====
// reduced 6502 core with a Wishbone classic master port
`timescale 1ns/1ps
module cpu6502Top import cpuPkg::*; (
  input  logic phi0,
  input  logic rst,
  output addrT busAdr,
  output byteT busWrData,
  input  byteT busRdData,
  output logic busWe,
  output logic busCyc,
  output logic busStb,
  input  logic busAck,
  output logic sync,
  input  logic nmi,
  input  logic irq
);

  logic nmiPending, irqPending, intTaken, intIsNmi;

  cpuCtrlIf ctrlBus ();

  sequencer sequencerInst (
    .phi0       (phi0),
    .rst        (rst),
    .ctrl       (ctrlBus.sequencer),
    .busRdData  (busRdData),
    .busAck     (busAck),
    .busWe      (busWe),
    .busCyc     (busCyc),
    .busStb     (busStb),
    .sync       (sync),
    .nmiPending (nmiPending),
    .irqPending (irqPending),
    .intTaken   (intTaken),
    .intIsNmi   (intIsNmi)
  );

  datapath datapathInst (
    .phi0      (phi0),
    .rst       (rst),
    .ctrl      (ctrlBus.datapath),
    .busRdData (busRdData),
    .busAdr    (busAdr),
    .busWrData (busWrData)
  );

  interruptControl interruptControlInst (
    .phi0       (phi0),
    .rst        (rst),
    .nmi        (nmi),
    .irq        (irq),
    .flagI      (ctrlBus.flagI),
    .intTaken   (intTaken),
    .intIsNmi   (intIsNmi),
    .nmiPending (nmiPending),
    .irqPending (irqPending)
  );

endmodule

// ==== testbench/cpuBus_properties.sv ====
// Wishbone classic handshake checks, bound to the core top level
`timescale 1ns/1ps
module cpuBusProperties import cpuPkg::*; (
  input logic phi0,
  input logic rst,
  input addrT busAdr,
  input byteT busWrData,
  input logic busWe,
  input logic busCyc,
  input logic busStb,
  input logic busAck,
  input logic sync
);

  // strobe only inside a cycle
  stbInCyc: assert property (@(posedge phi0) disable iff (rst) busStb |-> busCyc)
    else $error("busStb high without busCyc");

  // request held until the slave acks
  reqStable: assert property (@(posedge phi0) disable iff (rst)
    (busStb && !busAck) |=>
      (busStb && $stable(busAdr) && $stable(busWe) && $stable(busWrData)))
    else $error("bus request changed before busAck");

  quietInReset: assert property (@(posedge phi0) rst |=> !(busCyc || busStb || busWe || sync))
    else $error("bus control output active during reset");

endmodule

// ==== testbench/tbCpu.sv ====
// testbench for the reduced 6502 core
// runs the stim program through a wait-state memory and checks every bus write
`timescale 1ns/1ps
module tbCpu import cpuPkg::*; ();

  // layout of the stim image above the 64K memory
  localparam int PARAM_BASE = 32'h10000;
  localparam int WRITE_BASE = 32'h10010;
  localparam int STIM_SIZE = 32'h10010 + 3 * 64;
  localparam int CYCLES_PER_WRITE = 40;

  logic phi0 = 1'b0;
  logic rst;
  addrT busAdr;
  byteT busWrData;
  byteT busRdData;
  logic busWe, busCyc, busStb, busAck, sync, nmi, irq;

  byteT stimImage [0:STIM_SIZE-1];
  byteT mem [0:65535];
  int cycleCount = 0;
  int writeIndex = 0;
  int readIndex = 0;
  int writeCount, cycleLimit, irqCycle, nmiCycle, waitLeft;
  logic inAccess = 1'b0;
  logic [31:0] lcgState = 32'd44;

  cpu6502Top cpu6502Top_inst (
    .phi0      (phi0),
    .rst       (rst),
    .busAdr    (busAdr),
    .busWrData (busWrData),
    .busRdData (busRdData),
    .busWe     (busWe),
    .busCyc    (busCyc),
    .busStb    (busStb),
    .busAck    (busAck),
    .sync      (sync),
    .nmi       (nmi),
    .irq       (irq)
  );

  bind cpu6502Top cpuBusProperties cpuBusPropertiesInst (.*);

  function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic checkAddr(input addrT expected, input addrT actual, input string what);
    if (actual !== expected) begin
      abortRun($sformatf("mismatch at %0t: %s expected %h, got %h",
                         $time, what, expected, actual));
    end
  endtask

  task automatic checkData(input byteT expected, input byteT actual, input string what);
    if (actual !== expected) begin
      abortRun($sformatf("mismatch at %0t: %s expected %h, got %h",
                         $time, what, expected, actual));
    end
  endtask

  task automatic checkSync(input logic expected, input logic actual, input string what);
    if (actual !== expected) begin
      abortRun($sformatf("mismatch at %0t: %s expected %b, got %b",
                         $time, what, expected, actual));
    end
  endtask

  // reset reads FFFC and FFFD, then fetches the first opcode at that vector
  task automatic checkResetRead(input addrT adr, input logic fetching);
    addrT expAddr;
    if (readIndex < 3) begin
      if (readIndex == 2) expAddr = {mem[16'hFFFD], mem[16'hFFFC]};
      else expAddr = 16'hFFFC + addrT'(readIndex);
      checkAddr(expAddr, adr, $sformatf("address of read %0d", readIndex));
      checkSync(readIndex == 2, fetching, $sformatf("sync on read %0d", readIndex));
      readIndex = readIndex + 1;
    end
  endtask

  // next entry of the ordered write list
  task automatic checkWrite(input addrT adr, input byteT data);
    int base;
    addrT expAddr;
    byteT expData;
    base = WRITE_BASE + 3 * writeIndex;
    if (writeIndex >= writeCount) begin
      abortRun($sformatf("unexpected extra write of %h to %h at %0t", data, adr, $time));
    end
    expAddr = {stimImage[base], stimImage[base + 1]};
    expData = stimImage[base + 2];
    checkAddr(expAddr, adr, $sformatf("address of write %0d", writeIndex));
    checkData(expData, data, $sformatf("data of write %0d to %h", writeIndex, adr));
    writeIndex = writeIndex + 1;
  endtask

  initial begin
    forever #10 phi0 = ~phi0;
  end

  // memory model, interrupt lines and cycle count on the falling edge
  always @(negedge phi0) begin
    cycleCount = cycleCount + 1;
    irq = (cycleCount >= irqCycle);
    nmi = (cycleCount >= nmiCycle);
    if ((busCyc && busStb) !== 1'b1) begin
      inAccess = 1'b0;
      busAck = 1'b0;
    end else begin
      if (!inAccess) begin
        inAccess = 1'b1;
        lcgState = lcgNext(lcgState);
        waitLeft = lcgState[25:24];
      end else if (waitLeft > 0) begin
        waitLeft = waitLeft - 1;
      end
      if (waitLeft == 0) begin
        busAck = 1'b1;
        if (busWe) begin
          mem[busAdr] = busWrData;
          checkSync(1'b0, sync, $sformatf("sync on the write to %h", busAdr));
          checkWrite(busAdr, busWrData);
        end else begin
          busRdData = mem[busAdr];
          checkResetRead(busAdr, sync);
        end
      end
    end
  end

  initial begin
    rst = 1'b1;
    busRdData = '0;
    busAck = 1'b0;
    nmi = 1'b0;
    irq = 1'b0;
    // fill the unused memory with an address-dependent pattern
    for (int i = 0; i < STIM_SIZE; i++) begin
      stimImage[i] = (i < 32'h10000) ? byteT'(i[15:8] ^ i[7:0] ^ 8'h5A) : 8'h00;
    end
    $readmemh("testbench/cpu_stim.txt", stimImage);
    for (int i = 0; i < 65536; i++) begin
      mem[i] = stimImage[i];
    end
    irqCycle = {stimImage[PARAM_BASE], stimImage[PARAM_BASE + 1]};
    nmiCycle = {stimImage[PARAM_BASE + 2], stimImage[PARAM_BASE + 3]};
    writeCount = stimImage[PARAM_BASE + 4];
    cycleLimit = writeCount * CYCLES_PER_WRITE;
    if (writeCount == 0) begin
      abortRun("the stim file is missing or holds no expected writes");
    end
    repeat (3) @(posedge phi0);
    @(negedge phi0);
    rst = 1'b0;
    while (writeIndex < writeCount && cycleCount < cycleLimit) @(posedge phi0);
    if (writeIndex == writeCount) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      abortRun($sformatf("timeout after %0d cycles with %0d of %0d writes seen",
                         cycleCount, writeIndex, writeCount));
    end
  end

endmodule

// ==== testbench/cpu_stim.txt ====
// hex bytes by address: 0000-FFFF memory image, 10000 irq cycle (hi lo), nmi cycle (hi lo),
// write count, then from 10010 the expected writes in order as addr hi, addr lo, data
@0200
A9 11 A2 22 8D 00 04 8E 01 04   // LDA LDX STA STX
18 A9 35 69 27 8D 02 04         // CLC LDA ADC STA
38 69 B0 8D 03 04               // SEC ADC STA
38 E9 20 8D 04 04               // SEC SBC STA
18 E9 0C 8D 05 04               // CLC SBC STA
29 3C 09 05 8D 06 04            // AND ORA STA
49 FF 8D 07 04                  // EOR STA
F8 18 A9 38 69 45 8D 08 04      // SED CLC LDA ADC STA
38 E9 29 8D 09 04               // SEC SBC STA
69 47 8D 0A 04                  // ADC STA
D8 69 47 8D 0B 04               // CLD ADC STA
4C 50 02 A9 EE EA               // JMP over LDA
A9 00 F0 02 A9 BB D0 02 A9 C3 8D 0C 04
F0 02 A9 44 D0 02 A9 99 8D 0D 04
AA E8 8E 0E 04                  // TAX INX STX
58 EA 4C 6F 02                  // CLI NOP loop
@0300
A9 5A 8D 0F 04 4C 05 03         // irq handler
@0380
A9 A5 8D 10 04 4C 85 03         // nmi handler
@FFFA
80 03 00 02 00 03
@10000
00 40 02 D0 17
@10010
04 00 11  04 01 22  04 02 5C  04 03 0D
04 04 ED  04 05 E0  04 06 25  04 07 DA
04 08 83  04 09 54  04 0A 02  04 0B 4A
04 0C C3  04 0D 44  04 0E 45
01 FD 02  01 FC 6F  01 FB 20  04 0F 5A
01 FA 03  01 F9 05  01 F8 24  04 10 A5

// ==== filelist.f ====
logic/cpuPkg.sv
logic/cpuCtrlIf.sv
logic/alu.sv
logic/datapath.sv
logic/sequencer.sv
logic/interruptControl.sv
logic/cpu6502Top.sv
testbench/cpuBus_properties.sv
testbench/tbCpu.sv

// ==== Bender.yml ====
package:
  name: cpu6502

sources:
  - files:
      - logic/cpuPkg.sv
      - logic/cpuCtrlIf.sv
      - logic/alu.sv
      - logic/datapath.sv
      - logic/sequencer.sv
      - logic/interruptControl.sv
      - logic/cpu6502Top.sv
  - target: test
    files:
      - testbench/cpuBus_properties.sv
      - testbench/tbCpu.sv
